/* mduConsts.svh */
////////////////////
// mdu constants
// widths, divider step count and M-extension funct3 codes
////////////////////

`ifndef MDU_CONSTS_SVH
`define MDU_CONSTS_SVH

// data path
`define XLEN      32
`define DIV_STEPS 32   // one quotient bit per step
`define STEP_W    6    // must hold DIV_STEPS itself

// funct3 of the M extension, RISC-V order
`define F3_MUL    3'd0
`define F3_MULH   3'd1
`define F3_MULHSU 3'd2
`define F3_MULHU  3'd3
`define F3_DIV    3'd4
`define F3_DIVU   3'd5
`define F3_REM    3'd6
`define F3_REMU   3'd7

`endif

/* mduPkg.sv */
////////////////////
// mdu types
// request, multiplier stage word and divider state
////////////////////

`default_nettype none

`include "mduConsts.svh"

package mduPkg;

  // execute-stage request, operands already forwarded
  typedef struct packed {
    logic [2:0]       funct3;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
  } mduReq_t;

  // multiplier word held in the memory stage
  typedef struct packed {
    logic               valid;
    logic               selHigh;   // upper half wanted
    logic [2*`XLEN-1:0] product;
  } mulStage_t;

  typedef enum logic [1:0] {
    stIdle = 2'd0,
    stRun  = 2'd1,
    stDone = 2'd2
  } divState_t;

endpackage

`default_nettype wire

/* divCtrl.sv */
////////////////////
// mdu issue and divide control
// splits starts into multiply issue or divide load, sequences the divider
////////////////////

`default_nettype none

module divCtrl (
  input  logic       clk,
  input  logic       rstN,
  input  logic       startE,
  input  logic       flushE,
  input  logic [2:0] funct3E,
  input  logic       lastStep,
  output logic       mulIssue,
  output logic       divLoad,
  output logic       divStep,
  output logic       divDone,
  output logic       divBusyE
);

  import mduPkg::*;

  divState_t state, stateNext;

  // funct3[2] set means div/rem
  assign mulIssue = startE & ~funct3E[2];
  assign divLoad  = startE & funct3E[2];

  always_comb begin
    stateNext = state;
    case (state)
      stIdle: if (divLoad) stateNext = stRun;
      stRun:  if (lastStep) stateNext = stDone;
      stDone: stateNext = divLoad ? stRun : stIdle;  // back-to-back divide allowed
      default: stateNext = stIdle;
    endcase
    if (flushE && !divLoad) stateNext = stIdle;  // kills the divide in flight
  end

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) state <= stIdle;
    else       state <= stateNext;
  end

  assign divStep  = (state == stRun);
  assign divBusyE = (state == stRun);
  assign divDone  = (state == stDone);

  // hazard logic must hold the execute stage while busy
  assert property (@(posedge clk) disable iff (!rstN) startE |-> !divBusyE)
    else $error("mdu start while divider busy");

endmodule

`default_nettype wire

/* divCounter.sv */
////////////////////
// divider step counter
////////////////////

`default_nettype none

`include "mduConsts.svh"

module divCounter (
  input  logic clk,
  input  logic rstN,
  input  logic clear,
  input  logic step,
  output logic lastStep
);

  logic [`STEP_W-1:0] count;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN)      count <= '0;
    else if (clear) count <= '0;
    else if (step)  count <= count + 1'b1;
  end

  assign lastStep = step && (count == `STEP_W'(`DIV_STEPS - 1));  // 32nd step this cycle

  // controller must leave run on the last step
  assert property (@(posedge clk) disable iff (!rstN) count <= `STEP_W'(`DIV_STEPS))
    else $error("divider step count overran");

endmodule

`default_nettype wire

/* divDatapath.sv */
////////////////////
// divider datapath
// restoring shift-subtract on magnitudes, sign fix-up at the output
////////////////////

`default_nettype none

`include "mduConsts.svh"

module divDatapath (
  input  logic                 clk,
  input  logic                 rstN,
  input  logic                 load,
  input  logic                 step,
  input  mduPkg::mduReq_t      reqE,
  output logic [`XLEN-1:0]     divResult
);

  import mduPkg::*;

  logic             signedOp, isRem;
  logic             negA, negB;
  logic [`XLEN-1:0] absA, absB;

  logic [`XLEN-1:0] divisorQ;
  logic [`XLEN-1:0] quoQ;      // starts as the dividend, shifts out as quotient bits enter
  logic [`XLEN-1:0] remQ;
  logic             negQuoQ, negRemQ, isRemQ;

  logic [`XLEN:0]   shifted;
  logic [`XLEN+1:0] diff;
  logic [`XLEN-1:0] quoOut, remOut;

  ////////////////////
  // operand prep
  ////////////////////

  assign signedOp = (reqE.funct3 == `F3_DIV) || (reqE.funct3 == `F3_REM);
  assign isRem    = (reqE.funct3 == `F3_REM) || (reqE.funct3 == `F3_REMU);
  assign negA     = signedOp & reqE.srcA[`XLEN-1];
  assign negB     = signedOp & reqE.srcB[`XLEN-1];
  assign absA     = negA ? -reqE.srcA : reqE.srcA;
  assign absB     = negB ? -reqE.srcB : reqE.srcB;

  // sign flags and op select
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      negQuoQ <= 1'b0;
      negRemQ <= 1'b0;
      isRemQ  <= 1'b0;
    end else if (load) begin
      negQuoQ <= (negA ^ negB) & (|reqE.srcB);  // no negate on divide by zero
      negRemQ <= negA;
      isRemQ  <= isRem;
    end
  end

  ////////////////////
  // shift-subtract
  ////////////////////

  assign shifted = {remQ, quoQ[`XLEN-1]};
  assign diff    = {1'b0, shifted} - {2'b00, divisorQ};

  always_ff @(posedge clk) begin
    if (load) begin
      divisorQ <= absB;
      quoQ     <= absA;
      remQ     <= '0;
    end else if (step) begin
      if (!diff[`XLEN+1]) begin  // fits, keep the difference
        remQ <= diff[`XLEN-1:0];
        quoQ <= {quoQ[`XLEN-2:0], 1'b1};
      end else begin
        remQ <= shifted[`XLEN-1:0];
        quoQ <= {quoQ[`XLEN-2:0], 1'b0};
      end
    end
  end

  // restore signs
  assign quoOut    = negQuoQ ? -quoQ : quoQ;
  assign remOut    = negRemQ ? -remQ : remQ;
  assign divResult = isRemQ ? remOut : quoOut;

endmodule

`default_nettype wire

/* mulPipe.sv */
////////////////////
// multiplier, execute to memory
// 33x33 signed product covers all four variants
////////////////////

`default_nettype none

`include "mduConsts.svh"

module mulPipe (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  mulIssue,
  input  logic                  flushE,
  input  mduPkg::mduReq_t       reqE,
  output mduPkg::mulStage_t     mulStageM
);

  import mduPkg::*;

  logic                      signA, signB;
  logic signed [`XLEN:0]     aExt, bExt;
  logic signed [2*`XLEN+1:0] prodFull;

  logic                      validQ, selHighQ;
  logic [2*`XLEN-1:0]        productQ;

  // mulhsu treats only srcA as signed
  assign signA = (reqE.funct3 == `F3_MULH) || (reqE.funct3 == `F3_MULHSU);
  assign signB = (reqE.funct3 == `F3_MULH);

  assign aExt     = {signA & reqE.srcA[`XLEN-1], reqE.srcA};
  assign bExt     = {signB & reqE.srcB[`XLEN-1], reqE.srcB};
  assign prodFull = aExt * bExt;

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) validQ <= 1'b0;
    else       validQ <= mulIssue;
  end

  always_ff @(posedge clk) begin
    if (mulIssue) begin
      selHighQ <= (reqE.funct3 != `F3_MUL);
      productQ <= prodFull[2*`XLEN-1:0];
    end
  end

  // flush drops the product sitting in M
  assign mulStageM.valid   = validQ & ~flushE;
  assign mulStageM.selHigh = selHighQ;
  assign mulStageM.product = productQ;

endmodule

`default_nettype wire

/* mduWriteback.sv */
////////////////////
// mdu writeback register
// picks the product half or the divider result
////////////////////

`default_nettype none

`include "mduConsts.svh"

module mduWriteback (
  input  logic                  clk,
  input  logic                  rstN,
  input  mduPkg::mulStage_t     mulStageM,
  input  logic                  divDone,
  input  logic [`XLEN-1:0]      divResult,
  output logic [`XLEN-1:0]      resultW,
  output logic                  resultValidW
);

  import mduPkg::*;

  logic [`XLEN-1:0] mulResultM;

  assign mulResultM = mulStageM.selHigh ? mulStageM.product[2*`XLEN-1:`XLEN]
                                        : mulStageM.product[`XLEN-1:0];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) resultValidW <= 1'b0;
    else       resultValidW <= mulStageM.valid | divDone;
  end

  always_ff @(posedge clk) begin
    resultW <= mulStageM.valid ? mulResultM : divResult;
  end

  // busy blocks multiplies until the divide result has left
  assert property (@(posedge clk) disable iff (!rstN) !(mulStageM.valid && divDone))
    else $error("multiply and divide results collide in writeback");

endmodule

`default_nettype wire

/* mdu.sv */
////////////////////
// integer multiply/divide unit
////////////////////

`default_nettype none

`include "mduConsts.svh"

module mdu (
  input  logic              clk,
  input  logic              rstN,
  input  logic              startE,
  input  logic              flushE,
  input  mduPkg::mduReq_t   reqE,
  output logic              divBusyE,
  output logic [`XLEN-1:0]  resultW,
  output logic              resultValidW
);

  import mduPkg::*;

  logic             mulIssue, divLoad, divStep, divDone, lastStep;
  logic [`XLEN-1:0] divResult;
  mulStage_t        mulStageM;

  // issue and divide sequencing
  divCtrl u_divCtrl (
    .clk, .rstN, .startE, .flushE,
    .funct3E(reqE.funct3),
    .lastStep, .mulIssue, .divLoad, .divStep, .divDone, .divBusyE);

  divCounter u_divCounter (
    .clk, .rstN,
    .clear(divLoad),
    .step(divStep),
    .lastStep);

  divDatapath u_divDatapath (
    .clk, .rstN,
    .load(divLoad),
    .step(divStep),
    .reqE, .divResult);

  mulPipe u_mulPipe (.clk, .rstN, .mulIssue, .flushE, .reqE, .mulStageM);

  mduWriteback u_mduWriteback (
    .clk, .rstN, .mulStageM, .divDone, .divResult,
    .resultW, .resultValidW);

endmodule

`default_nettype wire

/* tbChecker.sv */
////////////////////
// mdu result checker
// queues expected results per start, compares them in order at writeback
////////////////////

`default_nettype none

`include "mduConsts.svh"

module tbChecker (
  input  logic              clk,
  input  logic              rstN,
  input  logic              startE,
  input  logic              flushE,
  input  mduPkg::mduReq_t   reqE,
  input  logic              divBusyE,
  input  logic [`XLEN-1:0]  resultW,
  input  logic              resultValidW,
  input  logic [`XLEN-1:0]  expValue,   // table value for directed rows
  input  logic              useModel,
  input  logic [8*12-1:0]   testName,
  output int                errorCount,
  output int                checkCount,
  output int                pendingCount
);

  import mduPkg::*;

  localparam int mulLatency = 2;
  localparam int divLatency = `DIV_STEPS + 2;

  typedef struct packed {
    logic [8*12-1:0]  name;
    logic             isDiv;
    logic [`XLEN-1:0] expected;
    int               issueCycle;
  } entry_t;

  entry_t     outstanding[$];
  entry_t     held;                 // start seen, flush not yet known
  logic       heldValid = 1'b0;
  logic       started = 1'b0;
  logic [1:0] busyHist = 2'b00;     // divBusyE two and one cycles back
  int         cycle = 0;
  int         flushDivCycle = -1;
  int         errors = 0;
  int         checks = 0;
  int         pending = 0;

  assign errorCount   = errors;
  assign checkCount   = checks;
  assign pendingCount = pending;

  ////////////////////
  // reference model
  ////////////////////

  function automatic logic [`XLEN-1:0] refModel(input logic [2:0] f3,
      input logic [`XLEN-1:0] a, input logic [`XLEN-1:0] b);
    logic [63:0]        ax, bx, prod;
    logic signed [31:0] sa, sb;
    ax = (f3 == `F3_MULH || f3 == `F3_MULHSU) ? {{32{a[31]}}, a} : {32'd0, a};
    bx = (f3 == `F3_MULH) ? {{32{b[31]}}, b} : {32'd0, b};
    prod = ax * bx;   // low 64 bits are exact for every variant
    sa = a;
    sb = b;
    case (f3)
      `F3_MUL: return prod[31:0];
      `F3_MULH, `F3_MULHSU, `F3_MULHU: return prod[63:32];
      `F3_DIV: begin
        if (b == 32'd0) return 32'hffff_ffff;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return a;  // overflow
        return sa / sb;
      end
      `F3_DIVU: return (b == 32'd0) ? 32'hffff_ffff : a / b;
      `F3_REM: begin
        if (b == 32'd0) return a;
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) return 32'd0;
        return sa % sb;   // sign follows the dividend
      end
      default: return (b == 32'd0) ? a : a % b;
    endcase
  endfunction

  task automatic flagProblem(input string msg);
    errors = errors + 1;
    $display("checker: %s at cycle %0d", msg, cycle);
  endtask

  ////////////////////
  // watch the ports mid-cycle
  ////////////////////

  always @(negedge clk) begin : watch
    entry_t e;
    if (!started && (divBusyE || resultValidW))
      flagProblem("mdu output active before the first start");
    if (rstN) begin
      cycle = cycle + 1;
      if (heldValid) begin
        if (held.isDiv && !divBusyE) flagProblem("divider not busy after a divide start");
        if (flushE) begin
          if (held.isDiv) flushDivCycle = cycle + 1;
        end else begin
          outstanding.push_back(held);
        end
        heldValid = 1'b0;
      end
      if (cycle == flushDivCycle && divBusyE)
        flagProblem("divider still busy after a flush");
      if (resultValidW) begin
        if (outstanding.size() == 0) begin
          flagProblem("result arrived with nothing outstanding");
        end else begin
          e = outstanding.pop_front();
          checks = checks + 1;
          if (resultW !== e.expected)
            $display("** Error %0s: expected %h, actual %h", e.name, e.expected, resultW);
          if (resultW !== e.expected) errors = errors + 1;
          if ((cycle - e.issueCycle) != (e.isDiv ? divLatency : mulLatency))
            flagProblem("result arrived at the wrong cycle");
          if (e.isDiv && busyHist != 2'b10)
            flagProblem("divide result not one cycle after busy fell");
        end
      end
      if (startE) begin
        if (divBusyE) flagProblem("start issued while the divider is busy");
        held.name       = testName;
        held.isDiv      = reqE.funct3[2];
        held.expected   = useModel ? refModel(reqE.funct3, reqE.srcA, reqE.srcB) : expValue;
        held.issueCycle = cycle;
        heldValid       = 1'b1;
        started         = 1'b1;
      end
      busyHist = {busyHist[0], divBusyE};
    end
    pending = outstanding.size() + (heldValid ? 1 : 0);
  end

endmodule

`default_nettype wire

/* tbMdu.sv */
////////////////////
// mdu testbench
// directed table then LCG operands, results checked in tbChecker
////////////////////

`default_nettype none

`include "mduConsts.svh"

module tbMdu;

  import mduPkg::*;

  localparam int          halfPeriod  = 50;
  localparam int          numDirected = 24;
  localparam int          numRandom   = 40;
  localparam int          waitLimit   = 200;   // cycles per wait loop
  localparam logic [31:0] seed        = 32'h04fd_fd3f;

  typedef struct packed {
    logic [8*12-1:0]  name;
    logic [2:0]       funct3;
    logic [`XLEN-1:0] srcA;
    logic [`XLEN-1:0] srcB;
    logic             flush;        // flushE in the cycle after the start
    logic             backToBack;   // start right after the previous one
    logic [`XLEN-1:0] expected;
  } row_t;

  logic             clk, rstN, startE, flushE, divBusyE, resultValidW;
  mduReq_t          reqE;
  logic [`XLEN-1:0] resultW, expValue;
  logic             useModel;
  logic [8*12-1:0]  testName;
  int               errorCount, checkCount, pendingCount;
  int               tbErrors = 0;
  logic [31:0]      lcgState;
  row_t             stimRows[numDirected];

  mdu u_mdu (.clk, .rstN, .startE, .flushE, .reqE, .divBusyE, .resultW, .resultValidW);

  tbChecker u_tbChecker (
    .clk, .rstN, .startE, .flushE, .reqE, .divBusyE, .resultW, .resultValidW,
    .expValue, .useModel, .testName, .errorCount, .checkCount, .pendingCount);

  initial begin
    clk = 1'b0;
    forever #halfPeriod clk = ~clk;
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic row_t mkRow(input logic [8*12-1:0] name, input logic [2:0] funct3,
      input logic [31:0] srcA, input logic [31:0] srcB, input logic flush,
      input logic backToBack, input logic [31:0] expected);
    row_t r;
    r.name       = name;
    r.funct3     = funct3;
    r.srcA       = srcA;
    r.srcB       = srcB;
    r.flush      = flush;
    r.backToBack = backToBack;
    r.expected   = expected;
    return r;
  endfunction

  function automatic row_t randomRow();
    row_t r;
    lcgState = lcgNext(lcgState);
    r.funct3 = lcgState[30:28];   // upper bits, low ones cycle too fast
    lcgState = lcgNext(lcgState);
    r.srcA = lcgState;
    lcgState = lcgNext(lcgState);
    r.srcB = lcgState[31] ? lcgState >> 24 : lcgState;   // some small divisors
    r.name = "random";
    r.flush = 1'b0;
    r.backToBack = 1'b0;
    r.expected = '0;
    return r;
  endfunction

  ////////////////////
  // stimulus table
  ////////////////////

  task automatic fillTable();
    stimRows[0]  = mkRow("mul_basic", `F3_MUL, 32'd7, 32'd6, 0, 0, 32'd42);
    stimRows[1]  = mkRow("mul_neg", `F3_MUL, 32'hffff_ffff, 32'd5, 0, 1, 32'hffff_fffb);
    stimRows[2]  = mkRow("mulh_min", `F3_MULH, 32'h8000_0000, 32'h8000_0000, 0, 1, 32'h4000_0000);
    stimRows[3]  = mkRow("mulh_max", `F3_MULH, 32'h7fff_ffff, 32'h7fff_ffff, 0, 1, 32'h3fff_ffff);
    stimRows[4]  = mkRow("mulhsu_neg", `F3_MULHSU, 32'hffff_ffff, 32'hffff_ffff, 0, 1, '1);
    stimRows[5]  = mkRow("mulhu_max", `F3_MULHU, 32'hffff_ffff, 32'hffff_ffff, 0, 1, 32'hffff_fffe);
    stimRows[6]  = mkRow("mulhu_small", `F3_MULHU, 32'h8000_0000, 32'd4, 0, 0, 32'd2);
    stimRows[7]  = mkRow("div_basic", `F3_DIV, 32'd100, 32'd7, 0, 0, 32'd14);
    stimRows[8]  = mkRow("div_neg", `F3_DIV, 32'hffff_ff9c, 32'd7, 0, 0, 32'hffff_fff2);
    stimRows[9]  = mkRow("div_negdiv", `F3_DIV, 32'd100, 32'hffff_fff9, 0, 0, 32'hffff_fff2);
    stimRows[10] = mkRow("rem_neg", `F3_REM, 32'hffff_ff9c, 32'd7, 0, 0, 32'hffff_fffe);
    stimRows[11] = mkRow("rem_negdiv", `F3_REM, 32'd100, 32'hffff_fff9, 0, 0, 32'd2);
    stimRows[12] = mkRow("divu_big", `F3_DIVU, 32'hffff_ffff, 32'h10, 0, 0, 32'h0fff_ffff);
    stimRows[13] = mkRow("remu_big", `F3_REMU, 32'hffff_ffff, 32'h10, 0, 0, 32'hf);
    stimRows[14] = mkRow("div_zero", `F3_DIV, 32'h1234_5678, 32'd0, 0, 0, 32'hffff_ffff);
    stimRows[15] = mkRow("divu_zero", `F3_DIVU, 32'h1234_5678, 32'd0, 0, 0, 32'hffff_ffff);
    stimRows[16] = mkRow("rem_zero", `F3_REM, 32'h8765_4321, 32'd0, 0, 0, 32'h8765_4321);
    stimRows[17] = mkRow("remu_zero", `F3_REMU, 32'h8765_4321, 32'd0, 0, 0, 32'h8765_4321);
    stimRows[18] = mkRow("div_ovf", `F3_DIV, 32'h8000_0000, 32'hffff_ffff, 0, 0, 32'h8000_0000);
    stimRows[19] = mkRow("rem_ovf", `F3_REM, 32'h8000_0000, 32'hffff_ffff, 0, 0, 32'd0);
    stimRows[20] = mkRow("mul_flush", `F3_MUL, 32'd3, 32'd3, 1, 0, 32'd9);
    stimRows[21] = mkRow("div_flush", `F3_DIV, 32'd50, 32'd5, 1, 0, 32'd10);
    stimRows[22] = mkRow("mul_after", `F3_MUL, 32'h1_0000, 32'h1_0000, 0, 0, 32'd0);
    stimRows[23] = mkRow("mulhsu_pos", `F3_MULHSU, 32'd2, 32'hffff_ffff, 0, 0, 32'd1);
  endtask

  // busy sampled mid-cycle, returns low ok on timeout
  task automatic waitDividerIdle(output logic ok);
    int waited;
    waited = 0;
    @(negedge clk);
    while (divBusyE && waited < waitLimit) begin
      @(negedge clk);
      waited++;
    end
    ok = !divBusyE;
    if (!ok) $display("timeout: divider stayed busy for %0d cycles", waitLimit);
  endtask

  task automatic waitDrained(output logic ok);
    int waited;
    waited = 0;
    @(posedge clk);
    while (pendingCount != 0 && waited < waitLimit) begin
      @(posedge clk);
      waited++;
    end
    ok = (pendingCount == 0);
    if (!ok) $display("timeout: %0d results never arrived", pendingCount);
  endtask

  ////////////////////
  // main sequence
  ////////////////////

  initial begin
    row_t r;
    logic model, ok;
    rstN = 1'b0;
    startE = 1'b0;
    flushE = 1'b0;
    reqE = '0;
    expValue = '0;
    useModel = 1'b0;
    testName = '0;
    ok = 1'b1;
    lcgState = seed;
    fillTable();
    repeat (5) @(posedge clk);
    rstN <= 1'b1;
    for (int i = 0; i < numDirected + numRandom; i++) begin
      if (i < numDirected) begin
        r = stimRows[i];
        model = 1'b0;
      end else begin
        r = randomRow();
        model = 1'b1;
      end
      if (!r.backToBack) begin
        @(posedge clk);
        startE <= 1'b0;
        flushE <= 1'b0;
        waitDividerIdle(ok);
        if (!ok) break;
      end
      @(posedge clk);
      startE      <= 1'b1;
      flushE      <= 1'b0;
      reqE.funct3 <= r.funct3;
      reqE.srcA   <= r.srcA;
      reqE.srcB   <= r.srcB;
      expValue    <= r.expected;
      useModel    <= model;
      testName    <= r.name;
      if (r.flush) begin
        @(posedge clk);
        startE <= 1'b0;
        flushE <= 1'b1;   // kills the op issued one cycle earlier
      end
    end
    @(posedge clk);
    startE <= 1'b0;
    flushE <= 1'b0;
    if (ok) waitDrained(ok);
    if (!ok) tbErrors = tbErrors + 1;
    repeat (4) @(posedge clk);   // catch stray results
    $display("mdu run: %0d results checked, %0d errors", checkCount, errorCount + tbErrors);
    if (errorCount + tbErrors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
+incdir+.
mduPkg.sv
divCtrl.sv
divCounter.sv
divDatapath.sv
mulPipe.sv
mduWriteback.sv
mdu.sv
tbChecker.sv
tbMdu.sv

/* Makefile */
SRCS := $(filter-out +incdir+%,$(shell cat list.f))

.PHONY: all run clean

all: run

obj_dir/VtbMdu: list.f mduConsts.svh $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tbMdu -f list.f -o VtbMdu

run: obj_dir/VtbMdu
	./obj_dir/VtbMdu | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
